//--- Makefile
SRCS := $(shell cat all.f)

.PHONY: all run clean

all: obj_dir/Vsdma_tb

obj_dir/Vsdma_tb: all.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module sdma_tb -f all.f

run: obj_dir/Vsdma_tb
	@out="$$(./obj_dir/Vsdma_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf obj_dir

//--- all.f
src/sdma_pkg.sv
src/sdma_ifs.sv
src/sdma_config.sv
src/sdma_block_fifo.sv
src/sdma_engine.sv
src/sdma_burst_writer.sv
src/sdma_top.sv
test/sdma_checker.sv
test/sdma_tb.sv

//--- src/sdma_block_fifo.sv
`default_nettype none

module sdma_block_fifo (
    input  logic            clock,
    input  logic            reset,
    input  sdma_pkg::word_t card_data,
    input  logic            card_valid,
    output logic            card_ready,
    input  logic            flush,
    input  logic            pop,
    output sdma_pkg::word_t rd_data,
    output logic [6:0]      level
);

    sdma_pkg::word_t mem [sdma_pkg::FIFO_DEPTH];
    logic [5:0] wr_ptr;
    logic [5:0] rd_ptr;
    logic push;
    logic take;

    assign card_ready = level != 7'(sdma_pkg::FIFO_DEPTH);

    // Nothing moves in the flush cycle
    assign push = card_valid && card_ready && !flush;
    assign take = pop && !flush;

    // Head word is always visible to the writer
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (!reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 6'd1;
            end
            if (take) begin
                rd_ptr <= rd_ptr + 6'd1;
            end
            level <= level + 7'(push) - 7'(take);
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= card_data;
        end
    end

    // A full buffer never takes another word
    level_bound: assert property (
        @(posedge clock) disable iff (!reset)
        level <= 7'(sdma_pkg::FIFO_DEPTH)
    );

    // Engine waits for a full burst, so the writer never pops empty
    pop_when_empty: assert property (
        @(posedge clock) disable iff (!reset)
        take |-> level != 7'd0
    );

endmodule

`default_nettype wire

//--- src/sdma_burst_writer.sv
`default_nettype none

module sdma_burst_writer (
    input  logic            clock,
    input  logic            reset,
    burst_if.slave          bus,
    input  sdma_pkg::word_t rd_data,
    output logic            pop,
    output sdma_pkg::word_t mem_awaddr,
    output logic            mem_awvalid,
    input  logic            mem_awready,
    output sdma_pkg::word_t mem_wdata,
    output logic            mem_wvalid,
    input  logic            mem_wready,
    output logic            mem_wlast
);

    localparam logic [3:0] LAST_BEAT = 4'(sdma_pkg::BURST_LEN - 1);

    typedef enum logic [1:0] {
        w_idle,
        w_addr,
        w_data,
        w_ack
    } wr_state_t;

    wr_state_t  state;
    logic [3:0] beat;
    logic       load;

    // Next buffer word goes into the data register
    assign load = bus.req && ((state == w_addr && mem_awready)
                || (state == w_data && mem_wready && beat != LAST_BEAT));
    assign pop = load;
    assign mem_wlast = mem_wvalid && beat == LAST_BEAT;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= w_idle;
            mem_awvalid <= 1'b0;
            mem_wvalid <= 1'b0;
            bus.ack <= 1'b0;
            beat <= '0;
        end else begin
            case (state)
                w_idle: begin
                    if (bus.req) begin
                        mem_awvalid <= 1'b1;
                        beat <= '0;
                        state <= w_addr;
                    end
                end
                w_addr: begin
                    if (mem_awready) begin
                        mem_awvalid <= 1'b0;
                        if (bus.req) begin
                            mem_wvalid <= 1'b1;
                            state <= w_data;
                        end else begin
                            state <= w_idle;
                        end
                    end
                end
                w_data: begin
                    // An abort ends the burst after the pending beat
                    if (mem_wready) begin
                        beat <= beat + 4'd1;
                        if (!bus.req || beat == LAST_BEAT) begin
                            mem_wvalid <= 1'b0;
                            if (bus.req) begin
                                bus.ack <= 1'b1;
                                state <= w_ack;
                            end else begin
                                state <= w_idle;
                            end
                        end
                    end
                end
                w_ack: begin
                    if (!bus.req) begin
                        bus.ack <= 1'b0;
                        state <= w_idle;
                    end
                end
                default: begin
                    state <= w_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == w_idle && bus.req) begin
            mem_awaddr <= bus.addr;
        end
        if (load) begin
            mem_wdata <= rd_data;
        end
    end

    aw_stable: assert property (
        @(posedge clock) disable iff (!reset)
        mem_awvalid && !mem_awready |=> mem_awvalid && $stable(mem_awaddr)
    );

endmodule

`default_nettype wire

//--- src/sdma_config.sv
`default_nettype none

module sdma_config (
    input  logic              clock,
    input  logic              reset,
    input  logic [2:0]        buf_boundary,
    input  sdma_pkg::blkcnt_t block_count,
    input  logic              count_ena,
    input  logic              start,
    input  sdma_pkg::word_t   sys_addr,
    input  logic              int_clear,
    output logic [1:0]        dma_interrupts,
    dma_cfg_if.config_side    cfg
);

    logic accept;

    // A start held high for several cycles is taken only once
    assign accept = start && !cfg.busy && !cfg.start_pulse;

    always_ff @(posedge clock) begin
        if (!reset) begin
            cfg.start_pulse <= 1'b0;
            dma_interrupts <= 2'b00;
        end else begin
            cfg.start_pulse <= accept;

            // Bit 1 boundary, bit 0 transfer complete
            if (int_clear) begin
                dma_interrupts <= 2'b00;
            end else begin
                dma_interrupts <= dma_interrupts
                                | {cfg.set_boundary_int, cfg.set_complete_int};
            end
        end
    end

    // Settings captured with the start
    always_ff @(posedge clock) begin
        if (accept) begin
            cfg.start_addr <= sys_addr;
            cfg.block_count <= block_count;
            cfg.count_ena <= count_ena;
            cfg.bound_blocks <= sdma_pkg::boundary_blocks(buf_boundary);
        end
    end

    // Engine must still be idle when the start arrives
    start_while_busy: assert property (
        @(posedge clock) disable iff (!reset)
        cfg.start_pulse |-> !cfg.busy
    );

endmodule

`default_nettype wire

//--- src/sdma_engine.sv
`default_nettype none

module sdma_engine (
    input  logic            clock,
    input  logic            reset,
    dma_cfg_if.engine_side  cfg,
    input  logic [6:0]      level,
    output logic            flush,
    input  sdma_pkg::word_t sys_addr,
    input  logic            sys_addr_load,
    input  logic            card_timeout,
    burst_if.master         bus
);

    localparam logic [2:0] LAST_BURST =
        3'(sdma_pkg::BLOCK_WORDS / sdma_pkg::BURST_LEN - 1);

    sdma_pkg::dma_state_t state;
    logic [2:0]        burst_cnt;
    sdma_pkg::blkcnt_t total_blks;
    sdma_pkg::blkcnt_t bound_cnt;
    sdma_pkg::word_t   burst_addr;
    logic              blocks_done;
    logic              bound_hit;

    // Block-end decisions, complete takes priority over boundary
    assign blocks_done = cfg.count_ena && total_blks == cfg.block_count;
    assign bound_hit = bound_cnt == cfg.bound_blocks;

    assign cfg.set_complete_int = state == sdma_pkg::block_check && blocks_done;
    assign cfg.set_boundary_int = state == sdma_pkg::block_check && !blocks_done
                                  && bound_hit;
    assign cfg.busy = state != sdma_pkg::idle;
    assign bus.addr = burst_addr;

    //////////////////////////////////////////////////////////////////////
    // SDMA control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= sdma_pkg::idle;
            bus.req <= 1'b0;
            flush <= 1'b0;
            burst_cnt <= '0;
            total_blks <= '0;
            bound_cnt <= '0;
            burst_addr <= '0;
        end else begin
            flush <= 1'b0;
            case (state)
                sdma_pkg::idle: begin
                    if (cfg.start_pulse) begin
                        // Drop leftovers of an earlier transfer
                        flush <= 1'b1;
                        burst_addr <= cfg.start_addr;
                        burst_cnt <= '0;
                        total_blks <= '0;
                        bound_cnt <= '0;
                        state <= sdma_pkg::wait_data;
                    end
                end
                sdma_pkg::wait_data: begin
                    // Level is stale while the flush is in progress
                    if (!flush && !bus.ack
                            && level >= 7'(sdma_pkg::BURST_LEN)) begin
                        bus.req <= 1'b1;
                        state <= sdma_pkg::burst;
                    end
                end
                sdma_pkg::burst: begin
                    if (bus.ack) begin
                        bus.req <= 1'b0;
                        burst_addr <= burst_addr + sdma_pkg::word_t'(sdma_pkg::BURST_BYTES);
                        burst_cnt <= burst_cnt + 3'd1;
                        if (burst_cnt == LAST_BURST) begin
                            total_blks <= total_blks + 1'b1;
                            bound_cnt <= bound_cnt + 1'b1;
                            state <= sdma_pkg::block_check;
                        end else begin
                            state <= sdma_pkg::wait_data;
                        end
                    end
                end
                sdma_pkg::block_check: begin
                    if (blocks_done) begin
                        state <= sdma_pkg::done;
                    end else if (bound_hit) begin
                        state <= sdma_pkg::boundary_wait;
                    end else begin
                        state <= sdma_pkg::wait_data;
                    end
                end
                sdma_pkg::boundary_wait: begin
                    // Software relocates the buffer
                    if (sys_addr_load) begin
                        burst_addr <= sys_addr;
                        bound_cnt <= '0;
                        state <= sdma_pkg::wait_data;
                    end
                end
                sdma_pkg::done: begin
                    state <= sdma_pkg::idle;
                end
                default: begin
                    state <= sdma_pkg::idle;
                end
            endcase

            // Serializer timeout aborts whatever is running
            if (card_timeout) begin
                state <= sdma_pkg::idle;
                bus.req <= 1'b0;
                flush <= 1'b1;
            end
        end
    end

    // Handshake order, only an abort may take req away early
    req_before_ack: assert property (
        @(posedge clock) disable iff (!reset)
        $fell(bus.req) |-> $past(bus.ack) || $past(card_timeout)
    );

endmodule

`default_nettype wire

//--- src/sdma_ifs.sv
`default_nettype none

// Transfer settings out to the engine, status pulses back
interface dma_cfg_if;
    logic              start_pulse;
    sdma_pkg::word_t   start_addr;
    sdma_pkg::blkcnt_t block_count;
    logic              count_ena;
    sdma_pkg::blkcnt_t bound_blocks;
    logic              set_boundary_int;
    logic              set_complete_int;
    logic              busy;

    modport config_side (
        output start_pulse, start_addr, block_count, count_ena, bound_blocks,
        input  set_boundary_int, set_complete_int, busy
    );

    modport engine_side (
        input  start_pulse, start_addr, block_count, count_ena, bound_blocks,
        output set_boundary_int, set_complete_int, busy
    );
endinterface

// Four-phase req/ack, one burst per handshake
interface burst_if;
    logic            req;
    logic            ack;
    sdma_pkg::word_t addr;

    modport master (
        output req, addr,
        input  ack
    );

    modport slave (
        input  req, addr,
        output ack
    );
endinterface

`default_nettype wire

//--- src/sdma_pkg.sv
`default_nettype none

package sdma_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and transfer geometry
    //////////////////////////////////////////////////////////////////////

    // Data and address word
    localparam int WORD_W = 32;

    // One memory burst is 16 beats of one word
    localparam int BURST_LEN = 16;
    localparam int BURST_BYTES = 64;

    // SD block of 512 bytes
    localparam int BLOCK_WORDS = 128;

    localparam int BLKCNT_W = 16;

    // Card-side buffer, four bursts deep
    localparam int FIFO_DEPTH = 64;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BLKCNT_W-1:0] blkcnt_t;

    // SDMA engine states
    typedef enum logic [2:0] {
        idle,
        wait_data,
        burst,
        block_check,
        boundary_wait,
        done
    } dma_state_t;

    //////////////////////////////////////////////////////////////////////
    // Buffer boundary
    //////////////////////////////////////////////////////////////////////

    // Code 0 is 4 KB (8 blocks), code 7 is 512 KB (1024 blocks)
    function automatic blkcnt_t boundary_blocks(input logic [2:0] code);
        blkcnt_t blocks;
        blocks = blkcnt_t'(8) << code;
        return blocks;
    endfunction

endpackage

`default_nettype wire

//--- src/sdma_top.sv
`default_nettype none

module sdma_top (
    input  logic              clock,
    input  logic              reset,
    // Card side
    input  sdma_pkg::word_t   card_data,
    input  logic              card_valid,
    output logic              card_ready,
    input  logic              card_timeout,
    // Software settings
    input  logic [2:0]        buf_boundary,
    input  sdma_pkg::blkcnt_t block_count,
    input  logic              count_ena,
    input  logic              start,
    input  sdma_pkg::word_t   sys_addr,
    input  logic              sys_addr_load,
    input  logic              int_clear,
    output logic [1:0]        dma_interrupts,
    output logic              busy,
    // Memory write port
    output sdma_pkg::word_t   mem_awaddr,
    output logic              mem_awvalid,
    input  logic              mem_awready,
    output sdma_pkg::word_t   mem_wdata,
    output logic              mem_wvalid,
    input  logic              mem_wready,
    output logic              mem_wlast
);

    dma_cfg_if cfg_bus ();
    burst_if   burst_bus ();

    logic [6:0]      level;
    logic            flush;
    logic            pop;
    sdma_pkg::word_t rd_data;

    assign busy = cfg_bus.busy;

    sdma_config config0 (
        .clock          (clock),
        .reset          (reset),
        .buf_boundary   (buf_boundary),
        .block_count    (block_count),
        .count_ena      (count_ena),
        .start          (start),
        .sys_addr       (sys_addr),
        .int_clear      (int_clear),
        .dma_interrupts (dma_interrupts),
        .cfg            (cfg_bus.config_side)
    );

    sdma_block_fifo fifo0 (
        .clock      (clock),
        .reset      (reset),
        .card_data  (card_data),
        .card_valid (card_valid),
        .card_ready (card_ready),
        .flush      (flush),
        .pop        (pop),
        .rd_data    (rd_data),
        .level      (level)
    );

    sdma_engine engine0 (
        .clock         (clock),
        .reset         (reset),
        .cfg           (cfg_bus.engine_side),
        .level         (level),
        .flush         (flush),
        .sys_addr      (sys_addr),
        .sys_addr_load (sys_addr_load),
        .card_timeout  (card_timeout),
        .bus           (burst_bus.master)
    );

    sdma_burst_writer writer0 (
        .clock       (clock),
        .reset       (reset),
        .bus         (burst_bus.slave),
        .rd_data     (rd_data),
        .pop         (pop),
        .mem_awaddr  (mem_awaddr),
        .mem_awvalid (mem_awvalid),
        .mem_awready (mem_awready),
        .mem_wdata   (mem_wdata),
        .mem_wvalid  (mem_wvalid),
        .mem_wready  (mem_wready),
        .mem_wlast   (mem_wlast)
    );

endmodule

`default_nettype wire

//--- test/sdma_checker.sv
`default_nettype none

module sdma_checker (
    input  logic              clock,
    input  logic              reset,
    input  int                case_idx,
    input  logic              case_end,
    input  sdma_pkg::word_t   mem_awaddr,
    input  logic              mem_awvalid,
    input  logic              mem_awready,
    input  sdma_pkg::word_t   mem_wdata,
    input  logic              mem_wvalid,
    input  logic              mem_wready,
    input  logic              mem_wlast,
    input  logic              card_valid,
    input  logic              card_ready,
    input  logic              card_timeout,
    input  logic              busy,
    input  logic [1:0]        dma_interrupts,
    input  logic              sys_addr_load,
    input  logic              int_clear,
    output int                errors,
    output int                checks
);
    timeunit 1ns;
    timeprecision 100ps;

    sdma_pkg::word_t s_start[$], s_count[$], s_ena[$], s_code[$];
    sdma_pkg::word_t s_reloc[$], s_base[$], s_tmo[$];

    // Progress within the current case
    int bursts = 0;
    int beats = 0;
    int seg = 0;
    int seg_start = 0;
    int words_in = 0;
    logic bound_pending = 1'b0;
    logic busy_drop = 1'b0;
    logic [1:0] prev_ints = 2'b00;
    logic prev_clear = 1'b0;

    initial begin
        int fd;
        int n;
        string line;
        sdma_pkg::word_t f [7];
        errors = 0;
        checks = 0;
        fd = $fopen("test/sdma_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                if (line.len() > 0 && line[0] != "#" && n == 7) begin
                    s_start.push_back(f[0]);
                    s_count.push_back(f[1]);
                    s_ena.push_back(f[2]);
                    s_code.push_back(f[3]);
                    s_reloc.push_back(f[4]);
                    s_base.push_back(f[5]);
                    s_tmo.push_back(f[6]);
                end
            end
            $fclose(fd);
        end
    end

    task automatic flag(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // Words the case moves when it runs to its end
    function automatic int case_words(input int c);
        if (s_ena[c][0]) begin
            return int'(s_count[c]) * sdma_pkg::BLOCK_WORDS;
        end
        return (8 << s_code[c][2:0]) * sdma_pkg::BLOCK_WORDS;
    endfunction

    always @(posedge clock) begin : compare
        sdma_pkg::word_t exp_addr;
        sdma_pkg::word_t exp_data;
        logic [1:0] rise;
        int bound_words;
        if (reset && case_idx < s_start.size()) begin
            bound_words = (8 << s_code[case_idx][2:0]) * sdma_pkg::BLOCK_WORDS;
            rise = dma_interrupts & ~prev_ints;

            ////////////////////////////////////////////////////////////////////
            // Card-side back-pressure and busy
            ////////////////////////////////////////////////////////////////////
            // At most one word sits in the data register
            if (s_tmo[case_idx] == 0) begin
                checks++;
                if (words_in - beats < sdma_pkg::FIFO_DEPTH && !card_ready) begin
                    flag($sformatf("case %0d card_ready low with %0d words held",
                                   case_idx, words_in - beats));
                end
                if (words_in - beats > sdma_pkg::FIFO_DEPTH && card_ready) begin
                    flag($sformatf("case %0d card_ready high with %0d words held",
                                   case_idx, words_in - beats));
                end
            end
            if (card_valid && card_ready) begin
                words_in++;
            end
            if (busy_drop && busy) begin
                flag($sformatf("case %0d busy still high after completion or abort",
                               case_idx));
            end

            ////////////////////////////////////////////////////////////////////
            // Memory address and data order
            ////////////////////////////////////////////////////////////////////
            if (mem_awvalid && bound_pending) begin
                flag("burst address issued during a boundary stop");
            end
            if (mem_awvalid && mem_awready) begin
                exp_addr = (seg == 0) ? s_start[case_idx] : s_reloc[case_idx];
                exp_addr = exp_addr
                         + sdma_pkg::word_t'(sdma_pkg::BURST_BYTES * (bursts - seg_start));
                checks++;
                if (mem_awaddr !== exp_addr) begin
                    flag($sformatf("case %0d burst %0d address %h, expected %h",
                                   case_idx, bursts, mem_awaddr, exp_addr));
                end
                bursts++;
            end
            if (mem_wvalid && mem_wready) begin
                exp_data = s_base[case_idx] + sdma_pkg::word_t'(beats);
                checks++;
                if (mem_wdata !== exp_data) begin
                    flag($sformatf("case %0d beat %0d data %h, expected %h",
                                   case_idx, beats, mem_wdata, exp_data));
                end
                if (mem_wlast !== (beats % sdma_pkg::BURST_LEN == sdma_pkg::BURST_LEN - 1)) begin
                    flag($sformatf("case %0d beat %0d wlast %b", case_idx, beats, mem_wlast));
                end
                beats++;
            end

            ////////////////////////////////////////////////////////////////////
            // Interrupts
            ////////////////////////////////////////////////////////////////////
            if (rise[0]) begin
                checks++;
                if (!s_ena[case_idx][0] || s_tmo[case_idx] != 0
                        || beats != case_words(case_idx)) begin
                    flag($sformatf("case %0d complete interrupt after %0d words",
                                   case_idx, beats));
                end
            end
            if (rise[1]) begin
                checks++;
                if (s_tmo[case_idx] != 0 || beats != bound_words * (seg + 1)) begin
                    flag($sformatf("case %0d boundary interrupt after %0d words",
                                   case_idx, beats));
                end
                bound_pending = 1'b1;
            end
            if (prev_clear && dma_interrupts != 2'b00) begin
                flag($sformatf("interrupts %b after int_clear", dma_interrupts));
            end
            if (sys_addr_load && bound_pending) begin
                seg++;
                seg_start = bursts;
                bound_pending = 1'b0;
            end

            // Engine is idle one cycle after completion or a timeout
            busy_drop = rise[0] || card_timeout;

            // Totals for the finished case
            if (case_end) begin
                checks++;
                if (s_tmo[case_idx] == 0 && (beats != case_words(case_idx)
                        || bursts * sdma_pkg::BURST_LEN != beats)) begin
                    flag($sformatf("case %0d moved %0d words in %0d bursts",
                                   case_idx, beats, bursts));
                end
                if (s_tmo[case_idx] != 0 && beats > int'(s_tmo[case_idx])) begin
                    flag($sformatf("case %0d wrote %0d words after abort", case_idx, beats));
                end
                bursts = 0;
                beats = 0;
                seg = 0;
                seg_start = 0;
                words_in = 0;
                bound_pending = 1'b0;
            end
        end
        prev_ints = dma_interrupts;
        prev_clear = int_clear;
    end

endmodule

`default_nettype wire

//--- test/sdma_stim.txt
# start_addr block_count count_ena boundary_code reloc_addr data_base timeout_after_words
# All columns hex, timeout_after_words 0 means the case runs to its end
# Counted transfer, three blocks
00001000 0003 1 0 00000000 10000000 0
# Boundary stop after 8 blocks, then relocation
00020000 000a 1 0 00080000 20000000 0
# Uncounted, boundary after 16 blocks
00030000 0002 0 1 00000000 30000000 0
# Timeout abort after 300 words
00040000 0003 1 0 00000000 40000000 12c
# Clean transfer from a flushed buffer
00050000 0002 1 0 00000000 50000000 0
# Two boundary stops in one counted transfer
00060000 0014 1 0 00090000 60000000 0

//--- test/sdma_tb.sv
`default_nettype none

module sdma_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic              clock;
    logic              reset;
    sdma_pkg::word_t   card_data;
    logic              card_valid;
    logic              card_ready;
    logic              card_timeout;
    logic [2:0]        buf_boundary;
    sdma_pkg::blkcnt_t block_count;
    logic              count_ena;
    logic              start;
    sdma_pkg::word_t   sys_addr;
    logic              sys_addr_load;
    logic              int_clear;
    logic [1:0]        dma_interrupts;
    logic              busy;
    sdma_pkg::word_t   mem_awaddr;
    logic              mem_awvalid;
    logic              mem_awready;
    sdma_pkg::word_t   mem_wdata;
    logic              mem_wvalid;
    logic              mem_wready;
    logic              mem_wlast;

    int              case_idx;
    logic            case_end;
    logic            card_en;
    int              card_target;
    sdma_pkg::word_t card_base;
    int              sent;
    int              cycles;
    int              limit;
    int              errors;
    int              checks;

    sdma_pkg::word_t s_start[$], s_count[$], s_ena[$], s_code[$];
    sdma_pkg::word_t s_reloc[$], s_base[$], s_tmo[$];

    sdma_top dut0 (.*);

    sdma_checker checker0 (.*);

    always #5 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Card and memory side drivers
    //////////////////////////////////////////////////////////////////////

    // Card words base plus index, with random gaps
    always @(posedge clock) begin : card_drive
        int nxt;
        if (!card_en) begin
            sent <= 0;
            card_valid <= 1'b0;
        end else begin
            nxt = sent + ((card_valid && card_ready) ? 1 : 0);
            sent <= nxt;
            if (nxt < card_target && $urandom_range(3) != 0) begin
                card_valid <= 1'b1;
                card_data <= card_base + sdma_pkg::word_t'(nxt);
            end else begin
                card_valid <= 1'b0;
            end
        end
    end

    always @(posedge clock) begin
        if (!reset) begin
            mem_awready <= 1'b0;
            mem_wready <= 1'b0;
        end else begin
            mem_awready <= $urandom_range(2) != 0;
            mem_wready <= $urandom_range(3) != 0;
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Run stopped: cycle limit of %0d reached before the cases finished", limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic int case_words(input int i);
        if (s_tmo[i] != 0) begin
            return int'(s_tmo[i]);
        end
        if (s_ena[i][0]) begin
            return int'(s_count[i]) * sdma_pkg::BLOCK_WORDS;
        end
        return (8 << s_code[i][2:0]) * sdma_pkg::BLOCK_WORDS;
    endfunction

    task automatic pulse_clear();
        int_clear <= 1'b1;
        @(posedge clock);
        int_clear <= 1'b0;
    endtask

    task automatic run_case(input int i);
        @(posedge clock);
        sys_addr <= s_start[i];
        block_count <= sdma_pkg::blkcnt_t'(s_count[i]);
        count_ena <= s_ena[i][0];
        buf_boundary <= s_code[i][2:0];
        start <= 1'b1;
        case_idx <= i;
        @(posedge clock);
        start <= 1'b0;
        // Card words only after the start flush
        while (!busy) @(posedge clock);
        card_base <= s_base[i];
        card_target <= case_words(i);
        card_en <= 1'b1;
        if (s_tmo[i] != 0) begin
            while (sent < int'(s_tmo[i])) @(posedge clock);
            card_timeout <= 1'b1;
            @(posedge clock);
            card_timeout <= 1'b0;
        end
        while (busy) begin
            @(posedge clock);
            if (dma_interrupts[1]) begin
                // Hold the stop a little so a stray burst would show
                repeat (3) @(posedge clock);
                pulse_clear();
                sys_addr <= s_reloc[i];
                if (s_ena[i][0]) begin
                    sys_addr_load <= 1'b1;
                end else begin
                    card_timeout <= 1'b1;
                end
                @(posedge clock);
                sys_addr_load <= 1'b0;
                card_timeout <= 1'b0;
            end
        end
        if (dma_interrupts[0]) begin
            pulse_clear();
        end
        while (mem_awvalid || mem_wvalid) @(posedge clock);
        card_en <= 1'b0;
        case_end <= 1'b1;
        @(posedge clock);
        case_end <= 1'b0;
    endtask

    initial begin
        int fd;
        int n;
        int total;
        string line;
        sdma_pkg::word_t f [7];
        void'($urandom(32'h77ec_f0d3));
        clock = 1'b0;
        reset = 1'b0;
        card_data = '0;
        card_valid = 1'b0;
        card_timeout = 1'b0;
        buf_boundary = '0;
        block_count = '0;
        count_ena = 1'b0;
        start = 1'b0;
        sys_addr = '0;
        sys_addr_load = 1'b0;
        int_clear = 1'b0;
        mem_awready = 1'b0;
        mem_wready = 1'b0;
        case_idx = 0;
        case_end = 1'b0;
        card_en = 1'b0;
        card_target = 0;
        card_base = '0;
        cycles = 0;
        limit = 0;
        total = 0;
        fd = $fopen("test/sdma_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file test/sdma_stim.txt");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                if (line.len() > 0 && line[0] != "#" && n == 7) begin
                    s_start.push_back(f[0]);
                    s_count.push_back(f[1]);
                    s_ena.push_back(f[2]);
                    s_code.push_back(f[3]);
                    s_reloc.push_back(f[4]);
                    s_base.push_back(f[5]);
                    s_tmo.push_back(f[6]);
                    total += case_words(s_start.size() - 1);
                end
            end
            $fclose(fd);
            limit = total * 8 + 2000;
            repeat (4) @(posedge clock);
            reset <= 1'b1;
            repeat (2) @(posedge clock);
            for (int i = 0; i < s_start.size(); i++) begin
                run_case(i);
            end
            repeat (5) @(posedge clock);
            $display("Cases: %0d, checks: %0d, errors: %0d", s_start.size(), checks, errors);
            if (errors == 0 && s_start.size() > 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
